// ==== core_top.f ====
design/rv_pkg.sv
design/core_controller.sv
design/pc_counter.sv
design/reg_file.sv
design/exec_unit.sv
design/core_top.sv
verification/core_tb.sv

// ==== design/core_controller.sv ====
`timescale 1ns/10ps

module core_controller (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  rv_pkg::word_t     inst_i,
  output rv_pkg::word_t     inst_o,
  output rv_pkg::ctrl_t     ctrl_o,
  output logic              pc_en_o,
  output logic              fetch_o,
  output rv_pkg::reg_addr_t rs1_addr_o,
  output rv_pkg::reg_addr_t rs2_addr_o,
  output rv_pkg::reg_addr_t rd_addr_o
);

  import rv_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  word_t       inst_q;
  opcode_t     opcode;
  logic [2:0]  funct3;
  logic        funct7_b5;

  // ----------------------------------------------------------
  // State register and instruction latch
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      state_q <= FETCH;
      inst_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == FETCH)
      begin
        inst_q <= inst_i;  // Memory answers combinationally
      end
    end
  end

  always_comb
  begin
    state_d = FETCH;
    case (state_q)
      FETCH:   state_d = EXE_1;
      EXE_1:   state_d = (opcode == OP_LOAD) ? EXE_2 : FETCH;
      EXE_2:   state_d = FETCH;
      default: state_d = FETCH;
    endcase
  end

  assign opcode    = inst_q[6:0];
  assign funct3    = inst_q[14:12];
  assign funct7_b5 = inst_q[30];

  assign inst_o     = inst_q;
  assign fetch_o    = (state_q == FETCH);
  assign rs1_addr_o = (opcode == OP_LUI) ? '0 : inst_q[19:15];  // LUI is x0 + imm
  assign rs2_addr_o = inst_q[24:20];
  assign rd_addr_o  = inst_q[11:7];

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  always_comb
  begin
    ctrl_o  = CTRL_IDLE;
    pc_en_o = 1'b0;

    case (state_q)
      EXE_1:
      begin
        pc_en_o = (opcode != OP_LOAD);  // LW steps the PC in EXE_2
        case (opcode)
          OP_ALU:
          begin
            ctrl_o.reg_write = 1'b1;
            case ({funct7_b5, funct3})
              4'b0000: ctrl_o.alu_op = ALU_ADD;
              4'b1000: ctrl_o.alu_op = ALU_SUB;
              4'b0001: ctrl_o.alu_op = ALU_SLL;
              4'b0010: ctrl_o.alu_op = ALU_SLT;
              4'b0011: ctrl_o.alu_op = ALU_SLTU;
              4'b0100: ctrl_o.alu_op = ALU_XOR;
              4'b0101: ctrl_o.alu_op = ALU_SRL;
              4'b1101: ctrl_o.alu_op = ALU_SRA;
              4'b0110: ctrl_o.alu_op = ALU_OR;
              4'b0111: ctrl_o.alu_op = ALU_AND;
              default: ctrl_o.alu_op = ALU_NOP;
            endcase
          end

          OP_ALUI:
          begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.src_b_imm = 1'b1;
            case (funct3)
              3'b000:  ctrl_o.alu_op = ALU_ADD;
              3'b001:  ctrl_o.alu_op = ALU_SLL;
              3'b010:  ctrl_o.alu_op = ALU_SLT;
              3'b011:  ctrl_o.alu_op = ALU_SLTU;
              3'b100:  ctrl_o.alu_op = ALU_XOR;
              3'b101:  ctrl_o.alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
              3'b110:  ctrl_o.alu_op = ALU_OR;
              default: ctrl_o.alu_op = ALU_AND;
            endcase
          end

          OP_LUI, OP_AUIPC:
          begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.src_a_pc  = (opcode == OP_AUIPC);
            ctrl_o.src_b_imm = 1'b1;
          end

          OP_BRANCH:
          begin
            ctrl_o.src_a_pc  = 1'b1;  // Target is PC + imm
            ctrl_o.src_b_imm = 1'b1;
            case (funct3)
              3'b000:  ctrl_o.branch_op = BR_BEQ;
              3'b001:  ctrl_o.branch_op = BR_BNE;
              3'b100:  ctrl_o.branch_op = BR_BLT;
              3'b101:  ctrl_o.branch_op = BR_BGE;
              3'b110:  ctrl_o.branch_op = BR_BLTU;
              3'b111:  ctrl_o.branch_op = BR_BGEU;
              default: ctrl_o.branch_op = BR_NONE;
            endcase
          end

          OP_JAL, OP_JALR:
          begin
            ctrl_o.reg_write  = 1'b1;
            ctrl_o.result_sel = RES_PC_PLUS4;  // Link value
            ctrl_o.src_a_pc   = (opcode == OP_JAL);
            ctrl_o.src_b_imm  = 1'b1;
            ctrl_o.branch_op  = BR_JUMP;
          end

          OP_LOAD:
          begin
            ctrl_o.src_b_imm = 1'b1;
            ctrl_o.mem_read  = 1'b1;
          end

          OP_STORE:
          begin
            ctrl_o.src_b_imm = 1'b1;
            case (funct3)
              3'b000:  ctrl_o.mem_be = 4'b0001;
              3'b001:  ctrl_o.mem_be = 4'b0011;
              3'b010:  ctrl_o.mem_be = 4'b1111;
              default: ctrl_o.mem_be = 4'b0000;
            endcase
          end

          default:
          begin
            ctrl_o = CTRL_IDLE;  // FENCE, SYSTEM and unknown opcodes
          end
        endcase
      end

      EXE_2:
      begin
        pc_en_o = 1'b1;
        if (opcode == OP_LOAD)
        begin
          ctrl_o.src_b_imm  = 1'b1;  // Hold the address
          ctrl_o.result_sel = RES_MEM;
          ctrl_o.reg_write  = 1'b1;
        end
      end

      default:
      begin
        ctrl_o  = CTRL_IDLE;
        pc_en_o = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_be_only_store: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (ctrl_o.mem_be != 4'b0000) |-> (state_q == EXE_1 && opcode == OP_STORE));

  a_no_pc_en_fetch: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (state_q == FETCH) |-> !pc_en_o);

  // One PC step per instruction, then a new fetch
  a_pc_en_once: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pc_en_o |=> (state_q == FETCH && !pc_en_o));

endmodule

// ==== design/core_top.sv ====
`timescale 1ns/10ps

module core_top #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk_i,
  input  logic          rstn_i,
  input  rv_pkg::word_t imem_data_i,
  input  rv_pkg::word_t dmem_rdata_i,
  output rv_pkg::word_t imem_addr_o,
  output logic          imem_rd_o,
  output rv_pkg::word_t dmem_addr_o,
  output rv_pkg::word_t dmem_wdata_o,
  output logic [3:0]    dmem_be_o,
  output logic          dmem_rd_o
);

  import rv_pkg::*;

  ctrl_t     ctrl;
  word_t     inst;
  word_t     pc;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     rd_data;
  word_t     alu_result;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  logic      pc_en;
  logic      take_branch;

  // ----------------------------------------------------------
  // Control and program counter
  // ----------------------------------------------------------
  core_controller u_ctrl (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .inst_i     (imem_data_i),
    .inst_o     (inst),
    .ctrl_o     (ctrl),
    .pc_en_o    (pc_en),
    .fetch_o    (imem_rd_o),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rd_addr_o  (rd_addr)
  );

  pc_counter #(
    .RESET_PC (RESET_PC)
  ) u_pc (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .pc_en_i       (pc_en),
    .take_branch_i (take_branch),
    .target_i      (alu_result),  // Branch or jump target
    .pc_o          (pc)
  );

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  reg_file u_rf (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .we_i       (ctrl.reg_write),
    .rd_addr_i  (rd_addr),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rd_data_i  (rd_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  exec_unit u_exe (
    .inst_i        (inst),
    .pc_i          (pc),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .mem_rdata_i   (dmem_rdata_i),
    .ctrl_i        (ctrl),
    .alu_result_o  (alu_result),
    .rd_data_o     (rd_data),
    .mem_wdata_o   (dmem_wdata_o),
    .mem_be_o      (dmem_be_o),
    .take_branch_o (take_branch)
  );

  assign imem_addr_o = pc;
  assign dmem_addr_o = alu_result;
  assign dmem_rd_o   = ctrl.mem_read;

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit (
  input  rv_pkg::word_t inst_i,
  input  rv_pkg::word_t pc_i,
  input  rv_pkg::word_t rs1_data_i,
  input  rv_pkg::word_t rs2_data_i,
  input  rv_pkg::word_t mem_rdata_i,
  input  rv_pkg::ctrl_t ctrl_i,
  output rv_pkg::word_t alu_result_o,
  output rv_pkg::word_t rd_data_o,
  output rv_pkg::word_t mem_wdata_o,
  output logic [3:0]    mem_be_o,
  output logic          take_branch_o
);

  import rv_pkg::*;

  opcode_t    opcode;
  word_t      imm;
  word_t      op_a;
  word_t      op_b;
  word_t      pc_plus4;
  logic [4:0] shamt;
  logic       br_eq;
  logic       br_lt;
  logic       br_ltu;

  assign opcode = inst_i[6:0];

  // ----------------------------------------------------------
  // Immediate generator
  // ----------------------------------------------------------
  always_comb
  begin
    case (opcode)
      OP_STORE:         imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      OP_BRANCH:        imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                               inst_i[30:25], inst_i[11:8], 1'b0};
      OP_LUI, OP_AUIPC: imm = {inst_i[31:12], 12'b0};
      OP_JAL:           imm = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                               inst_i[20], inst_i[30:21], 1'b0};
      default:          imm = {{20{inst_i[31]}}, inst_i[31:20]};  // I-type
    endcase
  end

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------
  assign op_a  = ctrl_i.src_a_pc ? pc_i : rs1_data_i;
  assign op_b  = ctrl_i.src_b_imm ? imm : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (ctrl_i.alu_op)
      ALU_ADD:  alu_result_o = op_a + op_b;
      ALU_SUB:  alu_result_o = op_a - op_b;
      ALU_SLL:  alu_result_o = op_a << shamt;
      ALU_SLT:  alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result_o = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result_o = op_a ^ op_b;
      ALU_SRL:  alu_result_o = op_a >> shamt;
      ALU_SRA:  alu_result_o = word_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_result_o = op_a | op_b;
      ALU_AND:  alu_result_o = op_a & op_b;
      default:  alu_result_o = '0;
    endcase
  end

  // Branch compare on the register operands
  assign br_eq  = (rs1_data_i == rs2_data_i);
  assign br_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign br_ltu = (rs1_data_i < rs2_data_i);

  always_comb
  begin
    case (ctrl_i.branch_op)
      BR_BEQ:  take_branch_o = br_eq;
      BR_BNE:  take_branch_o = !br_eq;
      BR_BLT:  take_branch_o = br_lt;
      BR_BGE:  take_branch_o = !br_lt;
      BR_BLTU: take_branch_o = br_ltu;
      BR_BGEU: take_branch_o = !br_ltu;
      BR_JUMP: take_branch_o = 1'b1;
      default: take_branch_o = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Store lanes and writeback
  // ----------------------------------------------------------
  always_comb
  begin
    case (inst_i[13:12])
      2'b00:   mem_wdata_o = {4{rs2_data_i[7:0]}};   // SB
      2'b01:   mem_wdata_o = {2{rs2_data_i[15:0]}};  // SH
      default: mem_wdata_o = rs2_data_i;
    endcase
  end

  assign mem_be_o = ctrl_i.mem_be << alu_result_o[1:0];  // Lanes follow the address

  assign pc_plus4 = pc_i + 32'd4;

  always_comb
  begin
    case (ctrl_i.result_sel)
      RES_PC_PLUS4: rd_data_o = pc_plus4;
      RES_MEM:      rd_data_o = mem_rdata_i;  // Full word only
      default:      rd_data_o = alu_result_o;
    endcase
  end

endmodule

// ==== design/pc_counter.sv ====
`timescale 1ns/10ps

module pc_counter #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk_i,
  input  logic          rstn_i,
  input  logic          pc_en_i,
  input  logic          take_branch_i,
  input  rv_pkg::word_t target_i,
  output rv_pkg::word_t pc_o
);

  import rv_pkg::*;

  word_t pc_next;

  always_comb
  begin
    if (take_branch_i)
    begin
      pc_next = {target_i[31:1], 1'b0};  // JALR clears bit 0
    end
    else
    begin
      pc_next = pc_o + 32'd4;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      pc_o <= RESET_PC;
    end
    else if (pc_en_i)
    begin
      pc_o <= pc_next;
    end
  end

  // No misaligned fetch trap exists, so targets must stay word aligned
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pc_o[1:0] == 2'b00);

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  logic              we_i,
  input  rv_pkg::reg_addr_t rd_addr_i,
  input  rv_pkg::reg_addr_t rs1_addr_i,
  input  rv_pkg::reg_addr_t rs2_addr_i,
  input  rv_pkg::word_t     rd_data_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o
);

  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we_i && (rd_addr_i != '0))
    begin
      regs[rd_addr_i] <= rd_data_i;  // x0 is never written
    end
  end

  // Asynchronous reads
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== design/rv_pkg.sv ====
package rv_pkg;

  // ----------------------------------------------------------
  // Basic word types
  // ----------------------------------------------------------
  typedef logic [31:0] word_t;      // Data or address word
  typedef logic [4:0]  reg_addr_t;  // Register index
  typedef logic [6:0]  opcode_t;    // inst[6:0]

  // RV32I base opcodes
  localparam opcode_t OP_ALU    = 7'b0110011;
  localparam opcode_t OP_ALUI   = 7'b0010011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_FENCE  = 7'b0001111;  // Retires as NOP
  localparam opcode_t OP_SYSTEM = 7'b1110011;  // Retires as NOP

  // ----------------------------------------------------------
  // Operation codes
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_NOP    // Result is zero
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JUMP    // JAL and JALR, always taken
  } branch_op_t;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_PC_PLUS4,
    RES_MEM
  } result_sel_t;

  typedef enum logic [1:0] {
    FETCH,
    EXE_1,
    EXE_2
  } ctrl_state_t;

  // ----------------------------------------------------------
  // Control bundle from the controller to the datapath
  // ----------------------------------------------------------
  typedef struct packed {
    alu_op_t     alu_op;
    branch_op_t  branch_op;
    result_sel_t result_sel;
    logic        src_a_pc;   // ALU A is PC instead of rs1
    logic        src_b_imm;  // ALU B is immediate instead of rs2
    logic        reg_write;
    logic        mem_read;
    logic [3:0]  mem_be;     // Unshifted store lanes
  } ctrl_t;

  localparam ctrl_t CTRL_IDLE = '{
    alu_op:     ALU_ADD,
    branch_op:  BR_NONE,
    result_sel: RES_ALU,
    src_a_pc:   1'b0,
    src_b_imm:  1'b0,
    reg_write:  1'b0,
    mem_read:   1'b0,
    mem_be:     4'b0000
  };

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module core_tb -f core_top.f -o core_tb_sim \
  && ./obj_dir/core_tb_sim | tee sim.log \
  || { echo "Build or simulation failed"; exit 1; }

grep -qx "Finished with no errors" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== verification/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;

  import rv_pkg::*;

  localparam word_t RESET_PC = 32'h0000_0100;
  localparam int    TIMEOUT  = 100;  // Cycles allowed per wait

  // RV32I major opcodes for I and U formats
  localparam word_t OPC_ALUI  = 32'h13;
  localparam word_t OPC_LOAD  = 32'h03;
  localparam word_t OPC_JALR  = 32'h67;
  localparam word_t OPC_LUI   = 32'h37;
  localparam word_t OPC_AUIPC = 32'h17;

  logic       clk_i;
  logic       rstn_i;
  word_t      imem_data_i;
  word_t      dmem_rdata_i;
  word_t      imem_addr_o;
  logic       imem_rd_o;
  word_t      dmem_addr_o;
  word_t      dmem_wdata_o;
  logic [3:0] dmem_be_o;
  logic       dmem_rd_o;

  word_t imem [128];
  word_t dmem [64];
  word_t program_q [$];
  word_t st_addr_q [$];   // Stores seen on the bus
  word_t st_data_q [$];   // Memory word after each store
  word_t exp_addr [$];
  word_t exp_data [$];
  string exp_name [$];
  int    error_count;
  int    test_count;

  core_top #(
    .RESET_PC (RESET_PC)
  ) dut (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .imem_data_i  (imem_data_i),
    .dmem_rdata_i (dmem_rdata_i),
    .imem_addr_o  (imem_addr_o),
    .imem_rd_o    (imem_rd_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_be_o    (dmem_be_o),
    .dmem_rd_o    (dmem_rd_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------
  // Instruction encoders
  // ----------------------------------------------------------
  function automatic word_t r_type(input word_t f7, input word_t f3, input word_t rd,
                                   input word_t rs1, input word_t rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t i_type(input word_t op, input word_t f3, input word_t rd,
                                   input word_t rs1, input word_t imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic word_t s_type(input word_t f3, input word_t rs2, input word_t rs1,
                                   input word_t imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(input word_t f3, input word_t rs1, input word_t rs2,
                                   input word_t imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'b1100011};
  endfunction

  function automatic word_t u_type(input word_t op, input word_t rd, input word_t imm);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic word_t j_type(input word_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  // ----------------------------------------------------------
  // Program and expected stores
  // ----------------------------------------------------------
  task automatic build_program();
    program_q.push_back(i_type(OPC_ALUI, 0, 10, 0, 512));   // x10 = 0x200 base
    program_q.push_back(i_type(OPC_ALUI, 0, 1, 0, 7));
    program_q.push_back(i_type(OPC_ALUI, 0, 2, 0, -12));
    program_q.push_back(r_type(0, 0, 3, 1, 2));             // add
    program_q.push_back(s_type(2, 3, 10, 0));
    program_q.push_back(r_type(32, 0, 3, 1, 2));            // sub
    program_q.push_back(s_type(2, 3, 10, 4));
    program_q.push_back(r_type(32, 5, 3, 2, 1));            // sra by x1
    program_q.push_back(s_type(2, 3, 10, 8));
    program_q.push_back(i_type(OPC_ALUI, 5, 3, 2, 4));      // srli
    program_q.push_back(s_type(2, 3, 10, 12));
    program_q.push_back(i_type(OPC_ALUI, 1, 3, 1, 28));     // slli
    program_q.push_back(s_type(2, 3, 10, 16));
    program_q.push_back(r_type(0, 2, 3, 2, 1));             // slt
    program_q.push_back(r_type(0, 3, 4, 2, 1));             // sltu
    program_q.push_back(i_type(OPC_ALUI, 1, 3, 3, 4));
    program_q.push_back(r_type(0, 6, 3, 3, 4));             // or
    program_q.push_back(i_type(OPC_ALUI, 3, 4, 1, -1));     // sltiu
    program_q.push_back(r_type(0, 0, 3, 3, 4));
    program_q.push_back(s_type(2, 3, 10, 20));
    program_q.push_back(i_type(OPC_ALUI, 4, 3, 2, 240));    // xori
    program_q.push_back(i_type(OPC_ALUI, 7, 3, 3, 2047));   // andi
    program_q.push_back(s_type(2, 3, 10, 24));
    program_q.push_back(u_type(OPC_LUI, 3, 32'hABCDE));
    program_q.push_back(s_type(2, 3, 10, 28));
    program_q.push_back(u_type(OPC_AUIPC, 3, 1));           // At 0x164
    program_q.push_back(s_type(2, 3, 10, 32));
    program_q.push_back(i_type(OPC_ALUI, 0, 0, 0, 55));     // Write to x0
    program_q.push_back(s_type(2, 0, 10, 36));
    // Taken branches skip the marker bit
    program_q.push_back(b_type(0, 1, 1, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 6, 6, 1));
    program_q.push_back(b_type(1, 1, 2, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 6, 6, 2));
    program_q.push_back(b_type(4, 2, 1, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 6, 6, 4));
    program_q.push_back(b_type(5, 1, 2, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 6, 6, 8));
    program_q.push_back(b_type(6, 1, 2, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 6, 6, 16));
    program_q.push_back(b_type(7, 2, 1, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 6, 6, 32));
    program_q.push_back(s_type(2, 6, 10, 40));
    // Branches not taken set every marker bit
    program_q.push_back(b_type(0, 1, 2, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 7, 7, 1));
    program_q.push_back(b_type(1, 1, 1, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 7, 7, 2));
    program_q.push_back(b_type(4, 1, 2, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 7, 7, 4));
    program_q.push_back(b_type(5, 2, 1, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 7, 7, 8));
    program_q.push_back(b_type(6, 2, 1, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 7, 7, 16));
    program_q.push_back(b_type(7, 1, 2, 8));
    program_q.push_back(i_type(OPC_ALUI, 6, 7, 7, 32));
    program_q.push_back(s_type(2, 7, 10, 44));
    program_q.push_back(j_type(8, 8));                      // jal at 0x1DC
    program_q.push_back(i_type(OPC_ALUI, 0, 9, 0, 1));      // Skipped
    program_q.push_back(s_type(2, 8, 10, 48));
    program_q.push_back(u_type(OPC_AUIPC, 5, 0));           // x5 = 0x1E8
    program_q.push_back(i_type(OPC_JALR, 0, 11, 5, 13));    // Odd target drops bit 0
    program_q.push_back(i_type(OPC_ALUI, 0, 9, 9, 2));      // Skipped
    program_q.push_back(s_type(2, 11, 10, 52));
    program_q.push_back(s_type(2, 9, 10, 56));
    program_q.push_back(u_type(OPC_LUI, 12, 32'h11223));
    program_q.push_back(i_type(OPC_ALUI, 0, 12, 12, 32'h344));
    program_q.push_back(s_type(2, 12, 10, 60));             // sw
    program_q.push_back(i_type(OPC_ALUI, 0, 13, 0, 32'hAB));
    program_q.push_back(s_type(0, 13, 10, 61));             // sb lane 1
    program_q.push_back(u_type(OPC_LUI, 13, 32'hD));
    program_q.push_back(i_type(OPC_ALUI, 0, 13, 13, -529)); // x13 = 0xCDEF
    program_q.push_back(s_type(1, 13, 10, 62));             // sh upper half
    program_q.push_back(i_type(OPC_LOAD, 2, 14, 10, 60));   // lw
    program_q.push_back(s_type(2, 14, 10, 64));
    program_q.push_back(j_type(0, 0));                      // Park here
  endtask

  task automatic add_expect(input word_t addr, input word_t data, input string name);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_name.push_back(name);
  endtask

  task automatic build_results();
    add_expect(32'h200, 32'hFFFF_FFFB, "add");
    add_expect(32'h204, 32'h0000_0013, "sub");
    add_expect(32'h208, 32'hFFFF_FFFF, "sra");
    add_expect(32'h20C, 32'h0FFF_FFFF, "srli");
    add_expect(32'h210, 32'h7000_0000, "slli");
    add_expect(32'h214, 32'h0000_0011, "slt sltu");
    add_expect(32'h218, 32'h0000_0704, "xori andi");
    add_expect(32'h21C, 32'hABCD_E000, "lui");
    add_expect(32'h220, 32'h0000_1164, "auipc");
    add_expect(32'h224, 32'h0000_0000, "x0 write");
    add_expect(32'h228, 32'h0000_0000, "branch taken");
    add_expect(32'h22C, 32'h0000_003F, "branch not taken");
    add_expect(32'h230, 32'h0000_01E0, "jal link");
    add_expect(32'h234, 32'h0000_01F0, "jalr link");
    add_expect(32'h238, 32'h0000_0000, "jump skips");
    add_expect(32'h23C, 32'h1122_3344, "sw");
    add_expect(32'h23C, 32'h1122_AB44, "sb");
    add_expect(32'h23C, 32'hCDEF_AB44, "sh");
    add_expect(32'h240, 32'hCDEF_AB44, "lw readback");
  endtask

  task automatic load_memories();
    for (int i = 0; i < 128; i++)
    begin
      // Filler past the program is addi x0, x0, i
      imem[i] = (i < program_q.size()) ? program_q[i] : i_type(OPC_ALUI, 0, 0, 0, i);
    end
    for (int i = 0; i < 64; i++)
    begin
      dmem[i] = 32'hC0DE_0000 + i * 257;
    end
  endtask

  task automatic compare_word(input string sig, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("** Error: %s is %h, expected %h", sig, got, exp);
      error_count++;
    end
  endtask

  // ----------------------------------------------------------
  // Memory models driven on the falling edge
  // ----------------------------------------------------------
  always @(negedge clk_i)
  begin
    if (imem_rd_o)
    begin
      imem_data_i = imem[7'((imem_addr_o - RESET_PC) >> 2)];  // Held outside FETCH
    end
    if (dmem_rd_o)
    begin
      dmem_rdata_i = dmem[dmem_addr_o[7:2]];  // Held through EXE_2
    end
    if (dmem_be_o != 4'b0000)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (dmem_be_o[b])
        begin
          dmem[dmem_addr_o[7:2]][8*b +: 8] = dmem_wdata_o[8*b +: 8];
        end
      end
      st_addr_q.push_back({dmem_addr_o[31:2], 2'b00});
      st_data_q.push_back(dmem[dmem_addr_o[7:2]]);
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial
  begin
    int    cycles;
    int    errors_before;
    bit    timed_out;
    word_t got_addr;
    word_t got_data;

    rstn_i       = 1'b0;
    imem_data_i  = '0;
    dmem_rdata_i = '0;
    error_count  = 0;
    test_count   = 0;
    timed_out    = 1'b0;
    build_program();
    build_results();
    load_memories();

    repeat (3) @(negedge clk_i);
    rstn_i = 1'b1;

    // First fetch comes from RESET_PC
    cycles = 0;
    while (!imem_rd_o && cycles < TIMEOUT)
    begin
      @(negedge clk_i);
      cycles++;
    end
    test_count++;
    errors_before = error_count;
    if (!imem_rd_o)
    begin
      $display("Test 0 reset fetch: no instruction fetch after reset");
      error_count++;
    end
    else
    begin
      compare_word("imem_addr_o", imem_addr_o, RESET_PC);
      $display("Test 0 reset fetch: %s", (error_count == errors_before) ? "ok" : "FAILED");
    end

    for (int k = 0; k < exp_addr.size(); k++)
    begin
      cycles = 0;
      while (st_addr_q.size() == 0 && cycles < TIMEOUT)
      begin
        @(posedge clk_i);
        cycles++;
      end
      test_count++;
      if (st_addr_q.size() == 0)
      begin
        $display("Test %0d %s: store to address %h never happened",
                 k + 1, exp_name[k], exp_addr[k]);
        error_count++;
        timed_out = 1'b1;
        break;
      end
      errors_before = error_count;
      got_addr = st_addr_q.pop_front();
      got_data = st_data_q.pop_front();
      compare_word("dmem_addr_o", got_addr, exp_addr[k]);
      compare_word("dmem word", got_data, exp_data[k]);
      $display("Test %0d %s: %s", k + 1, exp_name[k],
               (error_count == errors_before) ? "ok" : "FAILED");
    end

    $display("Tests run: %0d, errors: %0d%s", test_count, error_count,
             timed_out ? ", stopped on timeout" : "");
    if (error_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
